/* vlog.f */
verilog/l1d_pkg.sv
verilog/l1d_ifs.sv
verilog/l1d_data_array.sv
verilog/l2_handshake.sv
verilog/l1d_ctrl.sv
verilog/l1d_cache.sv
bench/clk_gen.sv
bench/l2_mem_model.sv
bench/tb_l1d_cache.sv

/* bench/tb_l1d_cache.sv */
module tb_l1d_cache;
    import l1d_pkg::*;

    localparam int clk_period  = 20;
    localparam int n_accesses  = 215;     // all cpu accesses of the run
    localparam int ack_timeout = 200;

    logic                   clk;
    logic                   nrst;
    logic                   cpu_req;
    logic                   cpu_we;
    logic [addr_w-1:0]      cpu_addr;
    logic [word_w-1:0]      cpu_wdata;
    logic                   flush;
    logic                   cpu_ack;
    logic [word_w-1:0]      cpu_rdata;
    logic                   miss;
    logic                   mem_req;
    logic                   mem_we;
    logic [line_addr_w-1:0] mem_addr;
    logic [line_w-1:0]      mem_wdata;
    logic                   mem_ack;
    logic [line_w-1:0]      mem_rdata;

    logic [31:0] lfsr;
    logic [word_w-1:0] ref_mem [int];   // words written by the cpu, by word address

    clk_gen #(.period(clk_period), .reset_cycles(5)) clk0 (.clk(clk), .nrst(nrst));

    l2_mem_model mem0 (
        .clk(clk), .nrst(nrst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    l1d_cache dut0 (
        .clk(clk), .nrst(nrst), .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .flush(flush), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .miss(miss), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    task automatic stop_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // word content before any write, depends on every address bit
    function automatic logic [31:0] init_word(input logic [13:0] wa);
        return {wa, 2'b01, ~wa, 2'b10};
    endfunction

    function automatic logic [31:0] exp_word(input logic [13:0] wa);
        if (ref_mem.exists(int'(wa)))
            return ref_mem[int'(wa)];
        return init_word(wa);
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] addr_of(input logic [7:0] tag, input logic [3:0] idx,
                                            input logic [1:0] off);
        return {tag, idx, off, 2'b00};
    endfunction

    // called and returns 2 units after a rising edge
    task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int edges, output int misses);
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        edges  = 0;
        misses = 0;
        do
        begin
            @(posedge clk);
            #2;
            edges++;
            if (miss)
                misses++;
            if (edges > ack_timeout)
            begin
                $display("timeout: no cpu_ack for access to address %h", addr);
                stop_failed();
            end
        end while (!cpu_ack);
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        @(posedge clk);
        #2;
        check_eq("cpu_ack one edge after cpu_req low", cpu_ack, 0);
        if (we)
            ref_mem[int'(addr[15:2])] = wdata;
    endtask

    task automatic read_check(input string what, input logic [15:0] addr, input int want_misses);
        logic [31:0] got;
        int edges;
        int misses;
        cpu_access(1'b0, addr, '0, got, edges, misses);
        check_eq({what, " data"}, got, exp_word(addr[15:2]));
        if (want_misses >= 0)
            check_eq({what, " miss pulses"}, misses, want_misses);
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                              input int want_misses);
        logic [31:0] got;
        int edges;
        int misses;
        cpu_access(1'b1, addr, data, got, edges, misses);
        if (want_misses >= 0)
            check_eq("write miss pulses", misses, want_misses);
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    // after a flush the truth is the initial image plus every written-back line
    task automatic reload_ref_from_log();
        ref_mem.delete();
        foreach (mem0.wr_addr_log[i])
            for (int w = 0; w < words_per_line; w++)
                ref_mem[int'({mem0.wr_addr_log[i], w[1:0]})] =
                    mem0.wr_line_log[i][w*word_w +: word_w];
    endtask

    task automatic reset_state();
        check_eq("cpu_ack after reset", cpu_ack, 0);
        check_eq("miss after reset", miss, 0);
        check_eq("mem_req after reset", mem_req, 0);
        repeat (10)
        begin
            @(posedge clk);
            #2;
            check_eq("l2 reads while idle", mem0.rd_count, 0);
            check_eq("l2 writes while idle", mem0.wr_count, 0);
        end
    endtask

    task automatic miss_then_hit();
        logic [31:0] got;
        int edges;
        int misses;
        int rd0;
        rd0 = mem0.rd_count;
        read_check("first read", addr_of(8'h01, 4'h1, 2'd2), 1);
        check_eq("l2 reads after miss", mem0.rd_count, rd0 + 1);
        check_eq("l2 read line address", mem0.last_rd_addr, {8'h01, 4'h1});
        cpu_access(1'b0, addr_of(8'h01, 4'h1, 2'd0), '0, got, edges, misses);
        check_eq("hit data", got, init_word({8'h01, 4'h1, 2'd0}));
        check_eq("hit miss pulses", misses, 0);
        check_eq("hit ack latency", edges, 2);
        check_eq("l2 reads after hit", mem0.rd_count, rd0 + 1);
    endtask

    task automatic write_hit();
        int rd0;
        int wr0;
        rd0 = mem0.rd_count;
        wr0 = mem0.wr_count;
        write_word(addr_of(8'h01, 4'h1, 2'd3), 32'hcafe_0013, 0);
        read_check("written word", addr_of(8'h01, 4'h1, 2'd3), 0);
        for (int off = 0; off < 3; off++)
            read_check("neighbour word", addr_of(8'h01, 4'h1, off[1:0]), 0);
        check_eq("l2 reads around write hit", mem0.rd_count, rd0);
        check_eq("l2 writes around write hit", mem0.wr_count, wr0);
    endtask

    task automatic lru_write_back();
        int rd0;
        int wr0;
        write_word(addr_of(8'h20, 4'h5, 2'd1), 32'h0b0b_5a5a, 1);    // B, dirty
        read_check("read A", addr_of(8'h10, 4'h5, 2'd1), 1);        // B becomes lru
        rd0 = mem0.rd_count;
        wr0 = mem0.wr_count;
        read_check("read C", addr_of(8'h30, 4'h5, 2'd1), 1);
        check_eq("l2 writes for victim", mem0.wr_count, wr0 + 1);
        check_eq("l2 reads for C", mem0.rd_count, rd0 + 1);
        check_eq("victim line address", mem0.wr_addr_log[$], {8'h20, 4'h5});
        check_eq("victim word", mem0.wr_line_log[$][word_w +: word_w], 32'h0b0b_5a5a);
        check_eq("read line address", mem0.last_rd_addr, {8'h30, 4'h5});
        read_check("read A again", addr_of(8'h10, 4'h5, 2'd1), 0);
        read_check("read B back", addr_of(8'h20, 4'h5, 2'd1), 1);
    endtask

    task automatic flush_drops_dirty();
        int wr0;
        read_check("read D", addr_of(8'h40, 4'h9, 2'd0), 1);
        wr0 = mem0.wr_count;
        write_word(addr_of(8'h40, 4'h9, 2'd0), 32'hdead_0009, 0);
        do_flush();
        reload_ref_from_log();
        read_check("read D after flush", addr_of(8'h40, 4'h9, 2'd0), 1);
        check_eq("l2 writes across flush", mem0.wr_count, wr0);
    endtask

    task automatic random_traffic();
        logic        we;
        logic [5:0]  wa;
        logic [31:0] data;
        for (int i = 0; i < 200; i++)
        begin
            we   = take_bits(1);
            wa   = take_bits(6);
            data = take_bits(32);
            if (we)
                write_word({8'h00, wa, 2'b00}, data, -1);
            else
                read_check("random read", {8'h00, wa, 2'b00}, -1);
        end
    endtask

    initial
    begin
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        flush     = 1'b0;
        lfsr      = 32'h19a38643;
        for (int la = 0; la < 2**line_addr_w; la++)
            for (int w = 0; w < words_per_line; w++)
                mem0.lines[la][w*word_w +: word_w] = init_word(la * words_per_line + w);
        @(posedge nrst);
        @(posedge clk);
        #2;
        reset_state();
        miss_then_hit();
        write_hit();
        lru_write_back();
        flush_drops_dirty();
        random_traffic();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // whole run bound, generous per access
    initial
    begin
        #(n_accesses * ack_timeout * clk_period);
        $display("watchdog expired: tests did not finish in time");
        stop_failed();
    end

endmodule

/* bench/l2_mem_model.sv */
module l2_mem_model (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            mem_req,
    input  logic                            mem_we,
    input  logic [l1d_pkg::line_addr_w-1:0] mem_addr,
    input  logic [l1d_pkg::line_w-1:0]      mem_wdata,
    output logic                            mem_ack,
    output logic [l1d_pkg::line_w-1:0]      mem_rdata
);
    import l1d_pkg::*;

    // filled by the testbench at time zero
    logic [line_w-1:0] lines [0:2**line_addr_w-1];

    int rd_count;
    int wr_count;
    logic [line_addr_w-1:0] last_rd_addr;
    logic [line_addr_w-1:0] wr_addr_log [$];
    logic [line_w-1:0]      wr_line_log [$];

    initial
    begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        rd_count  = 0;
        wr_count  = 0;
        last_rd_addr = '0;
        forever
        begin
            @(posedge clk);
            #2;
            if (nrst && mem_req)
            begin
                repeat (2) @(posedge clk);  // access latency
                #2;
                if (mem_we)
                begin
                    lines[mem_addr] = mem_wdata;
                    wr_addr_log.push_back(mem_addr);
                    wr_line_log.push_back(mem_wdata);
                    wr_count++;
                end
                else
                begin
                    mem_rdata    = lines[mem_addr];
                    last_rd_addr = mem_addr;
                    rd_count++;
                end
                mem_ack = 1'b1;
                do
                begin
                    @(posedge clk);
                    #2;
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

endmodule

/* bench/clk_gen.sv */
module clk_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic nrst
);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial
    begin
        nrst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 nrst = 1'b1;     // released clear of the edge
    end

endmodule

/* verilog/l1d_cache.sv */
module l1d_cache (
    input  logic                            clk,
    input  logic                            nrst,
    // cpu side
    input  logic                            cpu_req,
    input  logic                            cpu_we,
    input  logic [l1d_pkg::addr_w-1:0]      cpu_addr,
    input  logic [l1d_pkg::word_w-1:0]      cpu_wdata,
    input  logic                            flush,
    output logic                            cpu_ack,
    output logic [l1d_pkg::word_w-1:0]      cpu_rdata,
    output logic                            miss,
    // level two side
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [l1d_pkg::line_addr_w-1:0] mem_addr,
    output logic [l1d_pkg::line_w-1:0]      mem_wdata,
    input  logic                            mem_ack,
    input  logic [l1d_pkg::line_w-1:0]      mem_rdata
);

    l1d_array_if arr_if ();
    mem_port_if  mem_if ();

    l1d_ctrl u_ctrl (
        .clk       (clk),
        .nrst      (nrst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush     (flush),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .miss      (miss),
        .arr       (arr_if.ctrl),
        .mem       (mem_if.ctrl)
    );

    l1d_data_array u_data (
        .clk  (clk),
        .nrst (nrst),
        .arr  (arr_if.array)
    );

    l2_handshake u_l2 (
        .clk       (clk),
        .nrst      (nrst),
        .mem       (mem_if.port),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

/* verilog/l1d_ctrl.sv */
module l1d_ctrl (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       cpu_req,
    input  logic                       cpu_we,
    input  logic [l1d_pkg::addr_w-1:0] cpu_addr,
    input  logic [l1d_pkg::word_w-1:0] cpu_wdata,
    input  logic                       flush,
    output logic                       cpu_ack,
    output logic [l1d_pkg::word_w-1:0] cpu_rdata,
    output logic                       miss,
    l1d_array_if.ctrl                  arr,
    mem_port_if.ctrl                   mem
);
    import l1d_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE,
        DONE
    } state_t;

    state_t state, next_state;

    logic [tag_w-1:0] cpu_tag;
    logic [idx_w-1:0] index;
    logic [off_w-1:0] offset;

    logic [ways-1:0][tag_w-1:0] tag_mem [sets];
    logic [sets-1:0][ways-1:0]  valid;
    logic [sets-1:0][ways-1:0]  dirty;
    logic [sets-1:0]            lru;      // way to replace next

    logic [ways-1:0] match;
    logic            hit;
    logic            way_sel;            // hit way, else victim
    logic            way_reg;
    logic            victim_dirty;
    logic            start_q;

    // cpu holds the address until cpu_ack, so no copy is kept
    assign cpu_tag = cpu_addr[tag_lsb +: tag_w];
    assign index   = cpu_addr[idx_lsb +: idx_w];
    assign offset  = cpu_addr[off_lsb +: off_w];

    always_comb
    begin
        for (int w = 0; w < ways; w++)
            match[w] = valid[index][w] && (tag_mem[index][w] == cpu_tag);
    end

    assign hit = |match;

    // hit first, then a free way, then the lru choice
    always_comb
    begin
        if (match[0])
            way_sel = 1'b0;
        else if (match[1])
            way_sel = 1'b1;
        else if (!valid[index][0])
            way_sel = 1'b0;
        else if (!valid[index][1])
            way_sel = 1'b1;
        else
            way_sel = lru[index];
    end

    assign victim_dirty = valid[index][way_sel] && dirty[index][way_sel];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (cpu_req)
                    next_state = COMPARE;
            COMPARE:
                if (hit)
                    next_state = DONE;
                else if (victim_dirty)
                    next_state = WRITE_BACK;
                else
                    next_state = ALLOCATE;
            WRITE_BACK:
                if (mem.done)
                    next_state = ALLOCATE;
            ALLOCATE:
                if (mem.done)
                    next_state = COMPARE;   // retried, hits this time
            DONE:
                if (!cpu_req)
                    next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            miss    <= 1'b0;
            start_q <= 1'b0;
            way_reg <= 1'b0;
        end
        else
        begin
            miss    <= (state == COMPARE) && !hit;
            // kick level two on entry to WRITE_BACK or ALLOCATE
            start_q <= ((state == COMPARE) && !hit) || ((state == WRITE_BACK) && mem.done);
            if (state == COMPARE)
                way_reg <= way_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == COMPARE) && hit)
            cpu_rdata <= arr.rdata;
    end

    assign cpu_ack = (state == DONE);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (flush && !cpu_req)
                    begin
                        valid <= '0;    // dirty data is dropped
                        dirty <= '0;
                    end
                COMPARE:
                    if (hit)
                    begin
                        lru[index] <= ~way_sel;
                        if (cpu_we)
                            dirty[index][way_sel] <= 1'b1;
                    end
                ALLOCATE:
                    if (mem.done)
                    begin
                        valid[index][way_reg] <= 1'b1;
                        dirty[index][way_reg] <= 1'b0;
                    end
                default:
                    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ALLOCATE) && mem.done)
            tag_mem[index][way_reg] <= cpu_tag;
    end

    // the way is live from the compare, registered afterwards
    assign arr.index     = index;
    assign arr.way       = (state == COMPARE) ? way_sel : way_reg;
    assign arr.offset    = offset;
    assign arr.update    = (state == COMPARE) && hit && cpu_we;
    assign arr.wdata     = cpu_wdata;
    assign arr.refill    = (state == ALLOCATE) && mem.done;
    assign arr.fill_line = mem.rline;

    assign mem.start     = start_q;
    assign mem.we        = (state == WRITE_BACK);
    assign mem.line_addr = (state == WRITE_BACK) ? {tag_mem[index][way_reg], index}
                                                 : {cpu_tag, index};
    assign mem.wline     = arr.victim_line;

endmodule

/* verilog/l2_handshake.sv */
module l2_handshake (
    input  logic                            clk,
    input  logic                            nrst,
    mem_port_if.port                        mem,
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [l1d_pkg::line_addr_w-1:0] mem_addr,
    output logic [l1d_pkg::line_w-1:0]      mem_wdata,
    input  logic                            mem_ack,
    input  logic [l1d_pkg::line_w-1:0]      mem_rdata
);
    import l1d_pkg::*;

    typedef enum logic [1:0] {
        H_IDLE,
        H_REQ,      // req high, waiting for ack
        H_WAIT      // req low, waiting for ack to drop
    } hs_state_t;

    hs_state_t hs_state;

    logic [line_w-1:0] rline_q;
    logic              done_q;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hs_state <= H_IDLE;
            mem_we   <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (hs_state)
                H_IDLE:
                    if (mem.start)
                    begin
                        hs_state <= H_REQ;
                        mem_we   <= mem.we;
                    end
                H_REQ:
                    if (mem_ack)
                        hs_state <= H_WAIT;
                H_WAIT:
                    if (!mem_ack)
                    begin
                        hs_state <= H_IDLE;
                        mem_we   <= 1'b0;
                        done_q   <= 1'b1;
                    end
                default:
                    hs_state <= H_IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk)
    begin
        if ((hs_state == H_IDLE) && mem.start)
        begin
            mem_addr  <= mem.line_addr;
            mem_wdata <= mem.wline;
        end
        if ((hs_state == H_REQ) && mem_ack)
            rline_q <= mem_rdata;   // only meaningful for reads
    end

    assign mem_req   = (hs_state == H_REQ);
    assign mem.done  = done_q;
    assign mem.rline = rline_q;

endmodule

/* verilog/l1d_data_array.sv */
module l1d_data_array (
    input  logic       clk,
    input  logic       nrst,
    l1d_array_if.array arr
);
    import l1d_pkg::*;

    typedef logic [words_per_line-1:0][word_w-1:0] line_t;

    // one line per set and way
    line_t line_mem [sets][ways];

    line_t cur_line;
    line_t merged_line;

    // selected line, used for both reads
    assign cur_line = line_mem[arr.index][arr.way];

    always_comb
    begin
        merged_line = cur_line;
        merged_line[arr.offset] = arr.wdata;
    end

    // no writes while the controller is held in reset
    always_ff @(posedge clk)
    begin
        if (nrst)
        begin
            if (arr.refill)
                line_mem[arr.index][arr.way] <= arr.fill_line;
            else if (arr.update)
                line_mem[arr.index][arr.way] <= merged_line;   // write hit
        end
    end

    assign arr.rdata       = cur_line[arr.offset];
    assign arr.victim_line = cur_line;

endmodule

/* verilog/l1d_ifs.sv */
// controller <-> line storage
interface l1d_array_if;
    import l1d_pkg::*;

    logic [idx_w-1:0]  index;
    logic              way;
    logic [off_w-1:0]  offset;
    logic              update;        // merge wdata into one word
    logic [word_w-1:0] wdata;
    logic              refill;        // replace the whole line
    logic [line_w-1:0] fill_line;
    logic [word_w-1:0] rdata;         // combinational word read
    logic [line_w-1:0] victim_line;   // combinational line read

    modport ctrl (
        output index, way, offset, update, wdata, refill, fill_line,
        input  rdata, victim_line
    );

    modport array (
        input  index, way, offset, update, wdata, refill, fill_line,
        output rdata, victim_line
    );

endinterface

// controller <-> level two sequencer
interface mem_port_if;
    import l1d_pkg::*;

    logic                   start;      // one cycle
    logic                   we;
    logic [line_addr_w-1:0] line_addr;
    logic [line_w-1:0]      wline;
    logic                   done;       // one cycle
    logic [line_w-1:0]      rline;      // held after done

    modport ctrl (output start, we, line_addr, wline, input done, rline);

    modport port (input start, we, line_addr, wline, output done, rline);

endinterface

/* verilog/l1d_pkg.sv */
package l1d_pkg;

    // cpu side
    localparam int addr_w = 16;             // byte address
    localparam int word_w = 32;

    // line geometry
    localparam int words_per_line = 4;
    localparam int line_w = words_per_line * word_w;
    localparam int off_w = 2;               // word offset, byte bits below are dropped

    // set geometry
    localparam int sets = 16;
    localparam int idx_w = 4;

    // two ways only, the lru is a single bit per set
    localparam int ways = 2;

    // what is left of the address above index and offset
    localparam int tag_w = addr_w - idx_w - off_w - 2;

    // address of a whole line as level two sees it
    localparam int line_addr_w = tag_w + idx_w;

    // field positions inside cpu_addr
    localparam int off_lsb = 2;
    localparam int idx_lsb = off_lsb + off_w;
    localparam int tag_lsb = idx_lsb + idx_w;

endpackage
